// ==== rtl/mipsPkg.sv ====
/*
 * shared types of the single-cycle MIPS core
 * word and field widths, instruction and control structs,
 * opcode, function and ALU enums, core constants
 */
`default_nettype none

package mipsPkg;

    typedef logic [31:0] word_t;    // data, address and instruction word
    typedef logic [4:0]  regAddr_t;
    typedef logic [6:0]  memAddr_t; // data memory word index
    typedef logic [4:0]  shamt_t;

    localparam word_t    RESET_PC   = 32'h0000_0000;
    localparam regAddr_t LINK_REG   = 5'd31;    // jal return register
    localparam int       NUM_REGS   = 32;
    localparam int       DMEM_WORDS = 128;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } aluOp_e;

    // R-type field layout, immediate and jump index overlay the low bits
    typedef struct packed {
        logic [5:0] opcode;
        regAddr_t   rs;
        regAddr_t   rt;
        regAddr_t   rd;
        shamt_t     shamt;
        logic [5:0] funct;
    } instr_t;

    typedef struct packed {
        logic   regDst;     // write rd instead of rt
        logic   aluSrc;     // immediate as second operand
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   regWrite;
        logic   link;       // jal writes PC+4 to LINK_REG
        logic   branchEq;
        logic   branchNe;
        logic   jump;
        logic   jumpReg;
        aluOp_e aluOp;
    } ctrl_t;

    // sign-extended 16-bit immediate of an I-type word
    function automatic word_t signExtImm(input instr_t instr);
        logic [15:0] imm;
        imm = {instr.rd, instr.shamt, instr.funct};
        return {{16{imm[15]}}, imm};
    endfunction

endpackage

`default_nettype wire

// ==== rtl/mipsDecoder.sv ====
/*
 * main decoder of the single-cycle MIPS core
 * opcode and function code to control struct, ALU control folded in
 */
`timescale 1ns/1ps
`default_nettype none

module mipsDecoder import mipsPkg::*; (
    input  instr_t instr,
    output ctrl_t  ctrl
);

    always_comb begin
        ctrl = '0;  // unknown encodings stay inactive
        case (instr.opcode)
            OP_RTYPE: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (instr.funct)
                    FN_ADD: ctrl.aluOp = ALU_ADD;
                    FN_SUB: ctrl.aluOp = ALU_SUB;
                    FN_AND: ctrl.aluOp = ALU_AND;
                    FN_OR:  ctrl.aluOp = ALU_OR;
                    FN_SLT: ctrl.aluOp = ALU_SLT;
                    FN_SLL: ctrl.aluOp = ALU_SLL;
                    FN_SRL: ctrl.aluOp = ALU_SRL;
                    FN_JR: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.jumpReg  = 1'b1;   // target comes from rs
                    end
                    default: begin
                        ctrl = '0;
                    end
                endcase
            end
            OP_ADDI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_ADD;
            end
            OP_LW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_ADD;    // base plus offset
            end
            OP_SW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = ALU_ADD;
            end
            OP_BEQ: begin
                ctrl.branchEq = 1'b1;
                ctrl.aluOp    = ALU_SUB;
            end
            OP_BNE: begin
                ctrl.branchNe = 1'b1;
                ctrl.aluOp    = ALU_SUB;
            end
            OP_J: begin
                ctrl.jump = 1'b1;
            end
            OP_JAL: begin
                ctrl.jump = 1'b1;
                ctrl.link = 1'b1;   // return address into r31
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/registerFile.sv ====
/*
 * 32-entry general register file
 * two asynchronous reads, one write per cycle, jal link write
 */
`timescale 1ns/1ps
`default_nettype none

module registerFile import mipsPkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  instr_t instr,
    input  ctrl_t  ctrl,
    input  word_t  writeData,
    input  word_t  returnAddr,
    output word_t  rsData,
    output word_t  rtData
);

    word_t    regs [NUM_REGS];
    regAddr_t wrAddr;

    assign wrAddr = ctrl.regDst ? instr.rd : instr.rt;

    // r0 is hardwired to zero
    assign rsData = (instr.rs == '0) ? '0 : regs[instr.rs];
    assign rtData = (instr.rt == '0) ? '0 : regs[instr.rt];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite) begin
            if (wrAddr != '0) begin
                regs[wrAddr] <= writeData;
            end
        end else if (ctrl.link) begin
            regs[LINK_REG] <= returnAddr;   // jal
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mipsAlu.sv ====
/*
 * integer ALU of the single-cycle MIPS core
 * operand select, arithmetic, logic, shifts and the equality flag
 */
`timescale 1ns/1ps
`default_nettype none

module mipsAlu import mipsPkg::*; (
    input  instr_t instr,
    input  ctrl_t  ctrl,
    input  word_t  rsData,
    input  word_t  rtData,
    output word_t  result,
    output logic   equal
);

    word_t  opB;
    shamt_t shamt;

    assign opB   = ctrl.aluSrc ? signExtImm(instr) : rtData;
    assign shamt = instr.shamt;

    // drives beq and bne in the PC unit
    assign equal = (rsData == opB);

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD: result = rsData + opB;
            ALU_SUB: result = rsData - opB;
            ALU_AND: result = rsData & opB;
            ALU_OR:  result = rsData | opB;
            ALU_SLT: begin
                result = ($signed(rsData) < $signed(opB)) ? 32'd1 : 32'd0;
            end
            ALU_SLL: result = rtData << shamt;  // logical, rt is the source
            ALU_SRL: result = rtData >> shamt;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/pcUnit.sv ====
/*
 * program counter of the single-cycle MIPS core
 * next-PC selection for jr, j/jal and taken branches
 */
`timescale 1ns/1ps
`default_nettype none

module pcUnit import mipsPkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  instr_t instr,
    input  ctrl_t  ctrl,
    input  logic   equal,
    input  word_t  rsData,
    output word_t  pc,
    output word_t  pcPlus4
);

    word_t jumpTarget;
    word_t branchTarget;
    word_t nextPc;
    logic  branchTaken;

    assign pcPlus4      = pc + 32'd4;
    assign jumpTarget   = {pcPlus4[31:28], instr.rs, instr.rt, instr.rd,
                           instr.shamt, instr.funct, 2'b00};
    assign branchTarget = pcPlus4 + (signExtImm(instr) << 2);
    assign branchTaken  = (ctrl.branchEq & equal) | (ctrl.branchNe & ~equal);

    // jr wins over j, j over branches
    always_comb begin
        if (ctrl.jumpReg) begin
            nextPc = rsData;
        end else if (ctrl.jump) begin
            nextPc = jumpTarget;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/singleCycleMips.sv ====
/*
 * single-cycle MIPS integer core, top level
 * decoder, register file, ALU and PC unit plus the data memory port
 */
`timescale 1ns/1ps
`default_nettype none

module singleCycleMips import mipsPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    ir,            // instruction at irAddr
    output word_t    irAddr,
    input  word_t    readDataMem,
    output logic     cen,           // active low chip enable
    output logic     wen,           // active low write enable
    output logic     oen,           // active low output enable
    output memAddr_t addr,
    output word_t    data2Mem
);

    instr_t instr;
    ctrl_t  ctrl;
    word_t  rsData;
    word_t  rtData;
    word_t  aluResult;
    word_t  writeBack;
    word_t  pcPlus4;
    logic   equal;

    assign instr = instr_t'(ir);

    mipsDecoder i_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    registerFile i_regFile (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .ctrl       (ctrl),
        .writeData  (writeBack),
        .returnAddr (pcPlus4),
        .rsData     (rsData),
        .rtData     (rtData)
    );

    mipsAlu i_alu (
        .instr  (instr),
        .ctrl   (ctrl),
        .rsData (rsData),
        .rtData (rtData),
        .result (aluResult),
        .equal  (equal)
    );

    pcUnit i_pcUnit (
        .clk     (clk),
        .rst_n   (rst_n),
        .instr   (instr),
        .ctrl    (ctrl),
        .equal   (equal),
        .rsData  (rsData),
        .pc      (irAddr),
        .pcPlus4 (pcPlus4)
    );

    assign writeBack = ctrl.memToReg ? readDataMem : aluResult;

    // load: cen/oen low, store: cen/wen low, otherwise idle high
    assign cen      = ~(ctrl.memRead | ctrl.memWrite);
    assign wen      = ~ctrl.memWrite;
    assign oen      = ~ctrl.memRead;
    assign addr     = aluResult[8:2];   // byte address to word index
    assign data2Mem = rtData;

endmodule

`default_nettype wire

// ==== include/mipsRefModel.svh ====
/*
 * instruction-level reference model of the MIPS core
 * and a random generator of the supported instructions
 */
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

word_t  refRegs [NUM_REGS];
word_t  refMem  [DMEM_WORDS];
word_t  refPc;
integer refSeed = 40440;

function automatic int pickBelow(input int n);
    return int'($unsigned($random(refSeed)) % n);
endfunction

task automatic resetModel();
    refPc = RESET_PC;
    for (int i = 0; i < NUM_REGS; i++) begin
        refRegs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
        refMem[i] = '0;
    end
endtask

function automatic void writeModelReg(input regAddr_t r, input word_t v);
    if (r != '0) begin
        refRegs[r] = v;     // r0 stays zero
    end
endfunction

// executes one word and returns the expected memory port values
task automatic stepModel(input word_t ir, output logic expCen, output logic expWen,
                         output logic expOen, output memAddr_t expAddr,
                         output word_t expData);
    instr_t i;
    word_t  a;
    word_t  b;
    word_t  imm;
    word_t  ea;
    word_t  pcPlus4;
    i       = instr_t'(ir);
    a       = refRegs[i.rs];
    b       = refRegs[i.rt];
    imm     = {{16{ir[15]}}, ir[15:0]};     // sign-extended immediate
    ea      = a + imm;
    pcPlus4 = refPc + 32'd4;
    refPc   = pcPlus4;
    expCen  = 1'b1;
    expWen  = 1'b1;
    expOen  = 1'b1;
    expAddr = ea[8:2];      // only meaningful on lw and sw
    expData = b;
    case (i.opcode)
        OP_RTYPE: begin
            case (i.funct)
                FN_ADD: writeModelReg(i.rd, a + b);
                FN_SUB: writeModelReg(i.rd, a - b);
                FN_AND: writeModelReg(i.rd, a & b);
                FN_OR:  writeModelReg(i.rd, a | b);
                FN_SLT: writeModelReg(i.rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                FN_SLL: writeModelReg(i.rd, b << i.shamt);
                FN_SRL: writeModelReg(i.rd, b >> i.shamt);
                FN_JR:  refPc = a;
                default: ;
            endcase
        end
        OP_ADDI: writeModelReg(i.rt, ea);
        OP_LW: begin
            expCen = 1'b0;
            expOen = 1'b0;
            writeModelReg(i.rt, refMem[ea[8:2]]);
        end
        OP_SW: begin
            expCen = 1'b0;
            expWen = 1'b0;
            refMem[ea[8:2]] = b;
        end
        OP_BEQ: if (a == b) refPc = pcPlus4 + (imm << 2);
        OP_BNE: if (a != b) refPc = pcPlus4 + (imm << 2);
        OP_J:   refPc = {pcPlus4[31:28], ir[25:0], 2'b00};
        OP_JAL: begin
            writeModelReg(LINK_REG, pcPlus4);
            refPc = {pcPlus4[31:28], ir[25:0], 2'b00};
        end
        default: ;
    endcase
endtask

// kinds 0-6 R-type sll srl add sub and or slt, 7 addi, 8 lw, 9 sw,
// 10 beq, 11 bne, 12 j, 13 jal, 14 jr through r31
function automatic word_t drawInstr(input int idx, input int progLen,
                                    input int firstKind, input int lastKind);
    instr_t ins;
    int     kind;
    int     target;
    int     offset;
    ins    = instr_t'($random(refSeed));
    kind   = firstKind + pickBelow(lastKind - firstKind + 1);
    target = pickBelow(progLen);    // targets stay inside the program
    offset = target - (idx + 1);
    case (kind)
        0, 1, 2, 3, 4, 5, 6: begin
            ins.opcode = OP_RTYPE;
            case (kind)
                0: ins.funct = FN_SLL;
                1: ins.funct = FN_SRL;
                2: ins.funct = FN_ADD;
                3: ins.funct = FN_SUB;
                4: ins.funct = FN_AND;
                5: ins.funct = FN_OR;
                default: ins.funct = FN_SLT;
            endcase
            if (kind > 1) begin
                ins.shamt = '0;
            end
        end
        7: ins.opcode = OP_ADDI;
        8, 9: begin
            ins.opcode = (kind == 8) ? OP_LW : OP_SW;
            ins.rs     = '0;    // absolute word address always in range
            {ins.rd, ins.shamt, ins.funct} = 16'(pickBelow(DMEM_WORDS) * 4);
        end
        10, 11: begin
            ins.opcode = (kind == 10) ? OP_BEQ : OP_BNE;
            {ins.rd, ins.shamt, ins.funct} = offset[15:0];
        end
        12, 13: begin
            ins.opcode = (kind == 12) ? OP_J : OP_JAL;
            {ins.rs, ins.rt, ins.rd, ins.shamt, ins.funct} = 26'(target);
        end
        default: begin
            ins = '0;
            ins.opcode = OP_RTYPE;
            ins.funct  = FN_JR;
            ins.rs     = LINK_REG;
        end
    endcase
    return word_t'(ins);
endfunction

`endif

// ==== test/tbSingleCycleMips.sv ====
/*
 * testbench of the single-cycle MIPS core
 * clock, reset, instruction and data memory models,
 * random and directed programs checked against the reference model
 */
`timescale 1ns/1ps
`default_nettype none

module tbSingleCycleMips import mipsPkg::*; ();

    `include "mipsRefModel.svh"

    localparam int RESET_CYCLES = 5;
    localparam int PROG_WORDS   = 512;
    localparam int RESET_RUN    = 4;
    localparam int ALU_LEN      = 60;
    localparam int MEM_LEN      = 80;
    localparam int BR_LEN       = 60;
    localparam int BR_RUN       = 120;  // loops may run past the program
    localparam int JMP_RUN      = 12;
    localparam int MIX_LEN      = 400;
    localparam int DUMP_LEN     = 32;   // sw of r0..r31
    localparam int NUM_RESETS   = 6;
    localparam int CYCLE_LIMIT  = (RESET_RUN + ALU_LEN + MEM_LEN + 2 * DUMP_LEN + BR_RUN
                                   + JMP_RUN + MIX_LEN + NUM_RESETS * RESET_CYCLES) * 12 / 10;

    logic     clk = 1'b0;
    logic     rst_n;
    word_t    ir;
    word_t    irAddr;
    word_t    readDataMem;
    logic     cen;
    logic     wen;
    logic     oen;
    memAddr_t addr;
    word_t    data2Mem;

    word_t    prog [PROG_WORDS];
    word_t    dmem [DMEM_WORDS];
    int       errors      = 0;
    int       testErrors  = 0;
    int       testsRun    = 0;
    int       testsFailed = 0;
    int       cycles      = 0;

    singleCycleMips i_singleCycleMips (
        .clk         (clk),
        .rst_n       (rst_n),
        .ir          (ir),
        .irAddr      (irAddr),
        .readDataMem (readDataMem),
        .cen         (cen),
        .wen         (wen),
        .oen         (oen),
        .addr        (addr),
        .data2Mem    (data2Mem)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic word_t iTypeWord(input opcode_e op, input regAddr_t rs,
                                        input regAddr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jumpWord(input opcode_e op, input logic [25:0] index);
        return {op, index};
    endfunction

    function automatic word_t jrWord(input regAddr_t rs);
        return {OP_RTYPE, rs, 15'd0, FN_JR};
    endfunction

    // nop outside the program
    function automatic word_t fetchWord(input word_t pcAddr);
        if (pcAddr < 32'(PROG_WORDS * 4)) begin
            return prog[pcAddr[10:2]];
        end else begin
            return '0;
        end
    endfunction

    function automatic word_t fillWord(input int idx);
        return (32'(idx) * 32'h0204_0811) ^ 32'hc3a5_5a3c;
    endfunction

    task automatic checkIdle(input string where);
        if (irAddr !== RESET_PC || cen !== 1'b1 || wen !== 1'b1 || oen !== 1'b1) begin
            $display("FAIL %0t: %s irAddr=%h cen=%b wen=%b oen=%b",
                     $time, where, irAddr, cen, wen, oen);
            testErrors++;
        end
    endtask

    task automatic applyReset();
        ir          = '0;
        readDataMem = '0;
        rst_n       = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checkIdle("during reset");
        end
        rst_n = 1'b1;   // released on a falling edge
        checkIdle("after reset");
        resetModel();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]   = fillWord(i);
            refMem[i] = dmem[i];
        end
    endtask

    // one instruction per cycle from a falling edge
    task automatic runCycles(input int n);
        logic     expCen;
        logic     expWen;
        logic     expOen;
        memAddr_t expAddr;
        word_t    expData;
        logic     doWrite;
        memAddr_t wrAddr;
        word_t    wrData;
        for (int c = 0; c < n; c++) begin
            ir = fetchWord(irAddr);
            #1;
            readDataMem = dmem[addr];
            #1;
            if (irAddr !== refPc) begin
                $display("FAIL %0t: irAddr %h, expected %h", $time, irAddr, refPc);
                testErrors++;
            end
            stepModel(ir, expCen, expWen, expOen, expAddr, expData);
            if ({cen, wen, oen} !== {expCen, expWen, expOen}) begin
                $display("FAIL %0t: cen/wen/oen %b%b%b, expected %b%b%b for ir %h",
                         $time, cen, wen, oen, expCen, expWen, expOen, ir);
                testErrors++;
            end
            if (!expCen && addr !== expAddr) begin
                $display("FAIL %0t: addr %h, expected %h", $time, addr, expAddr);
                testErrors++;
            end
            if (!expWen && data2Mem !== expData) begin
                $display("FAIL %0t: data2Mem %h, expected %h", $time, data2Mem, expData);
                testErrors++;
            end
            doWrite = !cen && !wen;
            wrAddr  = addr;
            wrData  = data2Mem;
            @(posedge clk);
            if (doWrite) begin
                dmem[wrAddr] = wrData;
            end
            @(negedge clk);
        end
    endtask

    task automatic compareMemory();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            if (dmem[i] !== refMem[i]) begin
                $display("FAIL %0t: dmem[%0d] %h, expected %h", $time, i, dmem[i], refMem[i]);
                testErrors++;
            end
        end
    endtask

    task automatic randomBlock(input int first, input int len, input int progLen,
                               input int firstKind, input int lastKind);
        for (int i = first; i < first + len; i++) begin
            prog[i] = drawInstr(i, progLen, firstKind, lastKind);
        end
    endtask

    task automatic storeAllRegs(input int first);
        for (int k = 0; k < DUMP_LEN; k++) begin
            prog[first + k] = iTypeWord(OP_SW, 5'd0, 5'(k), 16'(k * 4));
        end
    endtask

    task automatic startTest();
        testErrors = 0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = '0;
        end
    endtask

    task automatic finishTest(input string name);
        compareMemory();
        testsRun++;
        if (testErrors == 0) begin
            $display("test %0d %s: ok", testsRun, name);
        end else begin
            $display("test %0d %s: %0d errors", testsRun, name, testErrors);
            testsFailed++;
        end
        errors += testErrors;
    endtask

    initial begin
        rst_n       = 1'b0;
        ir          = '0;
        readDataMem = '0;

        startTest();
        applyReset();
        runCycles(RESET_RUN);   // nops right after reset
        finishTest("reset");

        startTest();
        randomBlock(0, ALU_LEN, ALU_LEN, 0, 7);
        storeAllRegs(ALU_LEN);
        applyReset();
        runCycles(ALU_LEN + DUMP_LEN);
        finishTest("arithmetic and logic");

        startTest();
        randomBlock(0, MEM_LEN, MEM_LEN, 7, 9);
        storeAllRegs(MEM_LEN);
        applyReset();
        runCycles(MEM_LEN + DUMP_LEN);
        finishTest("loads and stores");

        startTest();
        for (int k = 1; k < NUM_REGS; k++) begin
            prog[k - 1] = iTypeWord(OP_ADDI, 5'd0, 5'(k), 16'(k % 4)); // many equal pairs
        end
        randomBlock(NUM_REGS - 1, BR_LEN, NUM_REGS - 1 + BR_LEN, 10, 11);
        applyReset();
        runCycles(BR_RUN);
        finishTest("branches");

        startTest();
        prog[0]  = jumpWord(OP_JAL, 26'd4);             // r31 = 4
        prog[1]  = iTypeWord(OP_SW, 5'd0, 5'd31, 16'd0);
        prog[2]  = iTypeWord(OP_ADDI, 5'd0, 5'd5, 16'd36);
        prog[3]  = jrWord(5'd5);                        // computed target is word 9
        prog[4]  = iTypeWord(OP_ADDI, 5'd0, 5'd2, 16'd7);
        prog[5]  = jrWord(LINK_REG);
        prog[9]  = jumpWord(OP_J, 26'd11);
        prog[11] = iTypeWord(OP_SW, 5'd0, 5'd2, 16'd4);
        prog[12] = jumpWord(OP_JAL, 26'd14);            // r31 = 52
        prog[14] = iTypeWord(OP_SW, 5'd0, 5'd31, 16'd8);
        applyReset();
        runCycles(JMP_RUN);
        if (dmem[0] !== 32'd4 || dmem[1] !== 32'd7 || dmem[2] !== 32'd52) begin
            $display("FAIL %0t: link words %h %h %h, expected 4 7 52",
                     $time, dmem[0], dmem[1], dmem[2]);
            testErrors++;
        end
        finishTest("jumps");

        startTest();
        randomBlock(0, MIX_LEN, MIX_LEN, 0, 14);
        applyReset();
        runCycles(MIX_LEN);
        finishTest("random mix");

        $display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
rtl/mipsPkg.sv
rtl/mipsDecoder.sv
rtl/registerFile.sv
rtl/mipsAlu.sv
rtl/pcUnit.sv
rtl/singleCycleMips.sv
test/tbSingleCycleMips.sv

// ==== Makefile ====
# Verilator build and run of the single-cycle MIPS testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       := tbSingleCycleMips
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

SOURCES := $(wildcard rtl/*.sv) $(wildcard include/*.svh) $(wildcard test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# the log search decides pass or fail
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
